//--- Makefile
# Verilator build and run for the sample batching streamer

VERILATOR ?= verilator
TOP       ?= batch_streamer_tb
LOG       ?= sim.log
SEED      ?= 23
BUILD     ?= obj_dir
FILELIST  ?= batch_streamer.f

PASS_TEXT := Finished with no errors
SOURCES   := $(wildcard src/*.sv src/*.svh test/*.sv)
BINARY    := $(BUILD)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR=$(VERILATOR) TOP=$(TOP) LOG=$(LOG) SEED=$(SEED)"

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary --timing -j 0 \
		-f $(FILELIST) \
		--top-module $(TOP) \
		-Mdir $(BUILD)

test: $(BINARY)
	./$(BINARY) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
		echo "Simulation passed, see $(LOG)"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- batch_streamer.f
+incdir+src
src/batch_streamer_pkg.sv
src/batch_control.sv
src/batch_store.sv
src/batch_framer.sv
src/batch_streamer.sv
test/batch_streamer_tb.sv

//--- src/batch_control.sv
// Fill/drain state machine with the store write and read address counters
`include "batch_streamer_defs.svh"

module batch_control (
    input  logic                            clock,
    input  logic                            rst,
    input  logic                            sample_valid,
    output logic                            sample_ready,
    input  logic                            slot_free,
    output logic                            write_enable,
    output batch_streamer_pkg::batch_addr_t write_addr,
    output batch_streamer_pkg::batch_addr_t read_addr,
    output logic                            load,
    output logic                            final_entry
);
    import batch_streamer_pkg::*;

    // Address of the last entry in a batch
    localparam batch_addr_t LAST_ADDR = batch_addr_t'(`BATCH_DEPTH - 1);

    batch_phase_t phase;
    batch_addr_t  write_count;
    batch_addr_t  read_count;

    // Set one cycle after the phase turns to drain
    // The first load waits for it, which places the first output beat
    // two edges after the edge that took the final sample
    logic         drain_started;

    // Samples are only taken while the batch is being filled
    assign sample_ready = (phase == PHASE_FILL);

    // A sample is written on every edge where it is accepted
    assign write_enable = sample_valid && sample_ready;
    assign write_addr   = write_count;

    // The store is read at the current drain position
    assign read_addr    = read_count;

    // The entry at the top address closes the batch
    assign final_entry  = (phase == PHASE_DRAIN) && (read_count == LAST_ADDR);

    // Hand an entry to the framer whenever its register can take one
    // In drain there is always at least one entry left, since the phase
    // returns to fill on the edge that loads the final one
    assign load = (phase == PHASE_DRAIN) && drain_started && slot_free;

    always_ff @(posedge clock) begin
        if (rst) begin
            phase         <= PHASE_FILL;
            write_count   <= '0;
            read_count    <= '0;
            drain_started <= 1'b0;
        end else begin
            case (phase)
                PHASE_FILL: begin
                    if (write_enable) begin
                        // The counter wraps back to zero after the top entry
                        write_count <= write_count + 1'b1;
                        // The batch is complete once the top address is written
                        if (write_count == LAST_ADDR) begin
                            phase <= PHASE_DRAIN;
                        end
                    end
                end

                PHASE_DRAIN: begin
                    drain_started <= 1'b1;
                    if (load) begin
                        // Read position also wraps to zero after the final entry
                        read_count <= read_count + 1'b1;
                        if (final_entry) begin
                            // Next batch may start while the last beat still waits
                            // in the framer for the sink
                            phase         <= PHASE_FILL;
                            drain_started <= 1'b0;
                        end
                    end
                end

                default: begin
                    phase <= PHASE_FILL;
                end
            endcase
        end
    end

endmodule

//--- src/batch_framer.sv
// Output register that holds a beat under back-pressure and marks the batch end
module batch_framer (
    input  logic                             clock,
    input  logic                             rst,
    input  logic                             load,
    input  batch_streamer_pkg::stream_beat_t entry,
    input  logic                             final_entry,
    output logic                             slot_free,
    output batch_streamer_pkg::stream_beat_t batch_beat,
    output logic                             batch_valid,
    input  logic                             batch_ready
);
    import batch_streamer_pkg::*;

    stream_beat_t beat_q;
    logic         valid_q;
    stream_beat_t framed;
    logic         take;

    // The register can take a new beat when it holds nothing
    // or when the held beat leaves on this edge
    assign slot_free = !valid_q || batch_ready;

    // Only capture when there is room, so a held beat is never replaced
    assign take = load && slot_free;

    // The final entry of a batch always closes the packet downstream
    // Any last flag set on an earlier sample is passed through unchanged
    always_comb begin
        framed      = entry;
        framed.last = entry.last | final_entry;
    end

    // Valid bit of the output register
    always_ff @(posedge clock) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (take) begin
            valid_q <= 1'b1;
        end else if (batch_ready) begin
            // Delivered with nothing to replace it
            valid_q <= 1'b0;
        end
    end

    // Payload only changes on a capture
    // While the sink stalls it keeps the same beat on the output
    always_ff @(posedge clock) begin
        if (take) begin
            beat_q <= framed;
        end
    end

    assign batch_beat  = beat_q;
    assign batch_valid = valid_q;

endmodule

//--- src/batch_store.sv
// Beat memory of one batch with synchronous write and asynchronous read
`include "batch_streamer_defs.svh"

module batch_store (
    input  logic                             clock,
    input  logic                             write_enable,
    input  batch_streamer_pkg::batch_addr_t  write_addr,
    input  batch_streamer_pkg::stream_beat_t write_beat,
    input  batch_streamer_pkg::batch_addr_t  read_addr,
    output batch_streamer_pkg::stream_beat_t read_beat
);
    import batch_streamer_pkg::*;

    // One entry per beat of the batch
    // Data, destination, user tag and last flag are kept together
    // so a single write stores the whole beat
    stream_beat_t entries [`BATCH_DEPTH];

    // Each accepted sample lands at the address given by the control
    // The control only raises write_enable during fill, so a batch
    // being played out is never overwritten
    always_ff @(posedge clock) begin
        if (write_enable) begin
            entries[write_addr] <= write_beat;
        end
    end

    // The read side returns the addressed entry in the same cycle
    // so the framer can capture it on the edge that load is high
    assign read_beat = entries[read_addr];

endmodule

//--- src/batch_streamer.sv
// Top level of the sample batching streamer wiring control, store and framer
module batch_streamer (
    input  logic                             clock,
    input  logic                             rst,
    input  batch_streamer_pkg::stream_beat_t sample_beat,
    input  logic                             sample_valid,
    output logic                             sample_ready,
    output batch_streamer_pkg::stream_beat_t batch_beat,
    output logic                             batch_valid,
    input  logic                             batch_ready
);
    import batch_streamer_pkg::*;

    // Store write side driven by the control
    logic         write_enable;
    batch_addr_t  write_addr;

    // Store read side and the entry it returns
    batch_addr_t  read_addr;
    stream_beat_t read_beat;

    // Handshake between control and framer
    logic         load;
    logic         final_entry;
    logic         slot_free;

    // Phase and address sequencing, the only place acceptance is decided
    batch_control control0 (
        .clock        (clock),
        .rst          (rst),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .slot_free    (slot_free),
        .write_enable (write_enable),
        .write_addr   (write_addr),
        .read_addr    (read_addr),
        .load         (load),
        .final_entry  (final_entry)
    );

    // Holds the beats of the batch in flight
    batch_store store0 (
        .clock        (clock),
        .write_enable (write_enable),
        .write_addr   (write_addr),
        .write_beat   (sample_beat),
        .read_addr    (read_addr),
        .read_beat    (read_beat)
    );

    // Presents one beat at a time to the downstream sink
    batch_framer framer0 (
        .clock        (clock),
        .rst          (rst),
        .load         (load),
        .entry        (read_beat),
        .final_entry  (final_entry),
        .slot_free    (slot_free),
        .batch_beat   (batch_beat),
        .batch_valid  (batch_valid),
        .batch_ready  (batch_ready)
    );

endmodule

//--- src/batch_streamer_defs.svh
// Batch depth and beat field width macros for the sample batching streamer
`ifndef BATCH_STREAMER_DEFS_SVH
`define BATCH_STREAMER_DEFS_SVH

// Number of beats collected before a batch is played out
// This has to be a power of two so the address counters wrap on their own
`define BATCH_DEPTH 8

// Width of one converter data word
`define SAMPLE_WIDTH 16

// Width of the destination channel carried with each beat
`define DEST_WIDTH 4

// Width of the user tag carried with each beat
`define USER_WIDTH 8

`endif

//--- src/batch_streamer_pkg.sv
// Field typedefs, the stream beat struct and the phase enum of the batching streamer
`include "batch_streamer_defs.svh"

package batch_streamer_pkg;

    // One converter data word
    typedef logic [`SAMPLE_WIDTH-1:0] sample_t;

    // Destination channel of a beat
    typedef logic [`DEST_WIDTH-1:0] dest_t;

    // Free user tag that travels with the sample
    typedef logic [`USER_WIDTH-1:0] user_t;

    // Address into the batch store
    // Wide enough to reach every entry of one batch
    typedef logic [$clog2(`BATCH_DEPTH)-1:0] batch_addr_t;

    // One stream beat as it moves through the design
    // The data word sits in the top bits and the last flag in bit 0
    typedef struct packed {
        sample_t data;
        dest_t   dest;
        user_t   user;
        logic    last;
    } stream_beat_t;

    // Phase of the single batch in flight
    // In fill the store takes samples, in drain it plays them out
    typedef enum logic {
        PHASE_FILL  = 1'b0,
        PHASE_DRAIN = 1'b1
    } batch_phase_t;

endpackage

//--- test/batch_streamer_tb.sv
// Table-driven testbench for the batching streamer with reference queue, checks and timeout
`include "batch_streamer_defs.svh"

module batch_streamer_tb;
    import batch_streamer_pkg::*;

    localparam int NUM_ROWS = 5;

    // Stimulus table with one column per array and one row per test
    // Batches is the number of full batches sent, stall is the chance in percent
    // that the sink holds batch_ready low, offer sets sample_valid during drain
    string row_name [NUM_ROWS] = '{
        "single_batch", "drain_offers", "back_to_back", "random_ready", "heavy_stall"
    };
    int row_batches [NUM_ROWS] = '{1, 1, 3, 4, 3};
    int row_stall_pct [NUM_ROWS] = '{0, 0, 0, 30, 50};
    bit row_offer_in_drain [NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1};

    logic         clock = 1'b0;
    logic         rst;
    stream_beat_t sample_beat;
    logic         sample_valid;
    logic         sample_ready;
    stream_beat_t batch_beat;
    logic         batch_valid;
    logic         batch_ready;

    // Beats the model expects at the output, oldest first
    stream_beat_t exp_q [$];

    int error_count = 0;
    int check_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_count = 0;
    int cycle_limit;
    int seed_dummy;

    batch_streamer dut0 (
        .clock        (clock),
        .rst          (rst),
        .sample_beat  (sample_beat),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .batch_beat   (batch_beat),
        .batch_valid  (batch_valid),
        .batch_ready  (batch_ready)
    );

    // Period of 40 time units
    always #20 clock = ~clock;

    // Ends the run if the DUT stops moving beats
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not complete within %0d clock cycles", cycle_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    // Field by field text of one beat for error lines
    function automatic string format_beat(input stream_beat_t b);
        return $sformatf("data=%h dest=%h user=%h last=%b", b.data, b.dest, b.user, b.last);
    endfunction

    // Compares one beat with the beat the model predicts
    task automatic check_beat(input string test, input stream_beat_t expected,
                              input stream_beat_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: expected %s, actual %s",
                     test, format_beat(expected), format_beat(actual));
        end
    endtask

    // Compares one handshake flag with its expected level
    task automatic check_flag(input string test, input string what, input logic expected,
                              input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: %s expected %b, actual %b", test, what, expected, actual);
        end
    endtask

    // Random converter sample with the input last flag set now and then
    function automatic stream_beat_t random_beat();
        stream_beat_t b;
        b.data = sample_t'($urandom);
        b.dest = dest_t'($urandom);
        b.user = user_t'($urandom);
        b.last = (($urandom % 6) == 0);
        return b;
    endfunction

    // Output beat for an accepted sample at position pos within its batch
    // The final position of a batch always closes the packet
    function automatic stream_beat_t frame_expect(input stream_beat_t offered, input int pos);
        stream_beat_t e;
        e = offered;
        e.last = offered.last | (pos == `BATCH_DEPTH - 1);
        return e;
    endfunction

    // Limit grows with the number of beats and leaves room for back-pressure
    function automatic int timeout_cycles();
        int total;
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total += row_batches[r];
        end
        return total * `BATCH_DEPTH * 2 * 4 + 100;
    endfunction

    // Prints the result line of one test and updates the counts
    task automatic report_test(input string test, input int errors_before, input int beats);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %-14s %3d beats  PASS", test, beats);
        end else begin
            tests_failed++;
            $display("test %-14s %3d beats  FAIL (%0d errors)", test, beats,
                     error_count - errors_before);
        end
    endtask

    // Idle state straight after reset
    task automatic check_reset_state();
        int errors_before;
        errors_before = error_count;
        @(negedge clock);
        check_flag("reset_state", "sample_ready", 1'b1, sample_ready);
        check_flag("reset_state", "batch_valid", 1'b0, batch_valid);
        report_test("reset_state", errors_before, 0);
    endtask

    // Sends all batches of one table row and checks every output beat
    // Inputs change on the falling edge, and outputs are read there too,
    // after the rising edge before it has settled them
    task automatic run_row(input int r);
        string test;
        int    total;
        int    sent;
        int    recvd;
        int    pos;
        int    n;
        int    rise_due;
        int    drain_until;
        int    errors_before;
        bit    done;
        begin
            test = row_name[r];
            total = row_batches[r] * `BATCH_DEPTH;
            sent = 0;
            recvd = 0;
            n = 0;
            rise_due = -1;
            drain_until = -1;
            errors_before = error_count;
            done = 1'b0;
            while (!done) begin
                @(negedge clock);
                n++;

                // First output beat shows two edges after the final accept
                if (n == rise_due - 1) begin
                    check_flag(test, "batch_valid one edge before first beat",
                               1'b0, batch_valid);
                end
                if (n == rise_due) begin
                    check_flag(test, "batch_valid two edges after final accept",
                               1'b1, batch_valid);
                end

                // No sample may be taken while the batch is drained
                if (n <= drain_until) begin
                    check_flag(test, "sample_ready during drain", 1'b0, sample_ready);
                end

                // A stalled beat must still match the head of the model queue,
                // so it cannot change until it has been delivered
                if (batch_valid) begin
                    if (exp_q.size() == 0) begin
                        error_count++;
                        $display("%s: the DUT presented an output beat when none was expected",
                                 test);
                    end else begin
                        check_beat(test, exp_q[0], batch_beat);
                    end
                end

                // Sink side
                if (row_stall_pct[r] == 0) begin
                    batch_ready = 1'b1;
                end else begin
                    batch_ready = (($urandom % 100) >= row_stall_pct[r]);
                end

                // Source side offers junk beats in drain when the row asks
                if (sent < total && sample_ready) begin
                    sample_beat = random_beat();
                    sample_valid = 1'b1;
                end else if (row_offer_in_drain[r] && !sample_ready) begin
                    sample_beat = random_beat();
                    sample_valid = 1'b1;
                end else begin
                    sample_beat = '0;
                    sample_valid = 1'b0;
                end

                // Handshakes that the next rising edge completes
                if (sample_valid && sample_ready) begin
                    pos = sent % `BATCH_DEPTH;
                    exp_q.push_back(frame_expect(sample_beat, pos));
                    sent++;
                    if (pos == `BATCH_DEPTH - 1) begin
                        // Drain lasts at least until all entries were loaded
                        drain_until = n + `BATCH_DEPTH + 1;
                        if (row_stall_pct[r] == 0) begin
                            rise_due = n + 3;
                        end
                    end
                end
                if (batch_valid && batch_ready && exp_q.size() > 0) begin
                    void'(exp_q.pop_front());
                    recvd++;
                end
                if (recvd == total) begin
                    done = 1'b1;
                end
            end

            // After the final delivery the DUT should be idle in fill
            @(negedge clock);
            sample_valid = 1'b0;
            sample_beat = '0;
            check_flag(test, "batch_valid after the row", 1'b0, batch_valid);
            check_flag(test, "sample_ready after the row", 1'b1, sample_ready);
            report_test(test, errors_before, total);
        end
    endtask

    initial begin
        seed_dummy = $urandom(23);
        cycle_limit = timeout_cycles();

        rst = 1'b1;
        sample_beat = '0;
        sample_valid = 1'b0;
        batch_ready = 1'b0;

        // Reset is held over four rising edges
        repeat (4) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        check_reset_state();
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        $display("Summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
